//--- policer_pkg.sv
/* Token-bucket policer shared definitions
   Port and field widths, stream metadata and the config write word */

package policer_pkg;

    //////////////////////////////////////////////////
    // Sizes

    localparam int num_ing_ports = 4;
    localparam int num_egr_ports = 4;

    // Wide enough for either side of the router
    localparam int port_w = $clog2((num_ing_ports > num_egr_ports) ? num_ing_ports
                                                                    : num_egr_ports);
    localparam int prio_w = 3;

    // Covers an MTU of 1500 bytes
    localparam int len_w  = 11;
    localparam int data_w = 64;

    // Bucket arithmetic is fixed point, 8 fraction bits
    localparam int frac_w  = 8;
    localparam int level_w = 32;

    // Table select codes on the config strobe
    localparam logic cir_table_sel = 1'b0;
    localparam logic cbs_table_sel = 1'b1;

    //////////////////////////////////////////////////
    // Field types

    typedef logic [port_w-1:0]          port_t;
    typedef logic [prio_w-1:0]          prio_t;
    typedef logic [len_w-1:0]           len_t;
    typedef logic [level_w-frac_w-1:0]  level_whole_t;

    //////////////////////////////////////////////////
    // Stream metadata

    // First-beat metadata from the parser
    typedef struct packed {
        port_t ingress_port;
        port_t egress_port;
        prio_t prio;
        len_t  byte_length;
    } packet_meta_t;

    // Same fields with the policer verdict appended
    typedef struct packed {
        port_t ingress_port;
        port_t egress_port;
        prio_t prio;
        len_t  byte_length;
        logic  policer_drop_mark;
    } policer_meta_t;

    //////////////////////////////////////////////////
    // Configuration words

    // Drain per clock, whole and fraction bytes
    typedef struct packed {
        logic [level_w-frac_w-1:0] whole;
        logic [frac_w-1:0]         fraction;
    } cir_t;

    // Burst size in whole bytes
    typedef struct packed {
        logic [level_w-1:0] burst_bytes;
    } cbs_t;

    // One data word, read as CIR or CBS by the table select
    typedef union packed {
        cir_t cir;
        cbs_t cbs;
    } cfg_word_u;

    typedef struct packed {
        logic      table_sel;
        port_t     port;
        cfg_word_u data;
    } cfg_write_t;

endpackage

//--- policer_config_regs.sv
/* Policer configuration tables
   Per-port CIR and CBS registers loaded from the write strobe */

`timescale 1ns/1ps

module policer_config_regs (
    input  logic                     core_clk_ifc,
    input  logic                     timer_reset,
    input  logic                     cfg_wr_en,
    input  policer_pkg::cfg_write_t  cfg_wr,
    output policer_pkg::cir_t        cir_table [policer_pkg::num_ing_ports],
    output policer_pkg::cbs_t        cbs_table [policer_pkg::num_ing_ports]
);

    logic [policer_pkg::num_ing_ports-1:0] cir_wr;
    logic [policer_pkg::num_ing_ports-1:0] cbs_wr;

    //////////////////////////////////////////////////
    // Write decode

    always_comb begin
        for (int i = 0; i < policer_pkg::num_ing_ports; i++) begin
            cir_wr[i] = cfg_wr_en && (cfg_wr.port == policer_pkg::port_t'(i)) &&
                        (cfg_wr.table_sel == policer_pkg::cir_table_sel);
            cbs_wr[i] = cfg_wr_en && (cfg_wr.port == policer_pkg::port_t'(i)) &&
                        (cfg_wr.table_sel == policer_pkg::cbs_table_sel);
        end
    end

    //////////////////////////////////////////////////
    // Table storage

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int i = 0; i < policer_pkg::num_ing_ports; i++) begin
                cir_table[i] <= '0;
                cbs_table[i] <= '0;
            end
        end else begin
            for (int i = 0; i < policer_pkg::num_ing_ports; i++) begin
                // Same word, decoded by which table it lands in
                if (cir_wr[i]) begin
                    cir_table[i] <= cfg_wr.data.cir;
                end
                if (cbs_wr[i]) begin
                    cbs_table[i] <= cfg_wr.data.cbs;
                end
            end
        end
    end

    // Software may only address ports that exist
    assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        cfg_wr_en |-> (int'(cfg_wr.port) < policer_pkg::num_ing_ports))
        else $error("config write to port %0d out of range", cfg_wr.port);

endmodule

//--- policer_bucket_bank.sv
/* Policer bucket bank
   One fixed-point level per port, drained by CIR each clock, charged on accept */

`timescale 1ns/1ps

module policer_bucket_bank (
    input  logic                        core_clk_ifc,
    input  logic                        timer_reset,
    input  policer_pkg::cir_t           cir_table [policer_pkg::num_ing_ports],
    input  logic                        charge_en,
    input  policer_pkg::port_t          charge_port,
    input  policer_pkg::len_t           charge_len,
    output policer_pkg::level_whole_t   levels [policer_pkg::num_ing_ports]
);

    logic [policer_pkg::level_w-1:0] level_q   [policer_pkg::num_ing_ports];
    logic [policer_pkg::level_w-1:0] drain_amt [policer_pkg::num_ing_ports];
    logic [policer_pkg::level_w-1:0] drained   [policer_pkg::num_ing_ports];

    // One extra bit to catch a carry out of the level
    logic [policer_pkg::level_w:0]   charge_amt;
    logic [policer_pkg::level_w:0]   charged_sum;

    //////////////////////////////////////////////////
    // Drain

    always_comb begin
        for (int i = 0; i < policer_pkg::num_ing_ports; i++) begin
            // CIR struct is already laid out as a fixed-point word
            drain_amt[i] = cir_table[i];
            // Floor at empty
            if (level_q[i] > drain_amt[i]) begin
                drained[i] = level_q[i] - drain_amt[i];
            end else begin
                drained[i] = '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Charge

    // Byte length moved up to the fixed-point scale
    assign charge_amt  = (policer_pkg::level_w + 1)'({charge_len, {policer_pkg::frac_w{1'b0}}});
    assign charged_sum = {1'b0, drained[charge_port]} + charge_amt;

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int i = 0; i < policer_pkg::num_ing_ports; i++) begin
                level_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < policer_pkg::num_ing_ports; i++) begin
                if (charge_en && (charge_port == policer_pkg::port_t'(i))) begin
                    level_q[i] <= charged_sum[policer_pkg::level_w-1:0];
                end else begin
                    level_q[i] <= drained[i];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Whole-byte view for the marker

    always_comb begin
        for (int i = 0; i < policer_pkg::num_ing_ports; i++) begin
            levels[i] = level_q[i][policer_pkg::level_w-1:policer_pkg::frac_w];
        end
    end

    // The marker's CBS check has to keep every charge inside the level range
    assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        charge_en |-> !charged_sum[policer_pkg::level_w])
        else $error("bucket level on port %0d wrapped", charge_port);

endmodule

//--- policer_marker.sv
/* Policer marking stage
   Registers the stream, decides the drop mark on each first beat and charges the bucket */

`timescale 1ns/1ps

module policer_marker (
    input  logic                              core_clk_ifc,
    input  logic                              timer_reset,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic                              in_last,
    input  logic [policer_pkg::data_w-1:0]    in_data,
    input  policer_pkg::packet_meta_t         in_meta,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic                              out_last,
    output logic [policer_pkg::data_w-1:0]    out_data,
    output policer_pkg::policer_meta_t        out_meta,
    input  logic [policer_pkg::num_ing_ports-1:0] port_enable,
    input  policer_pkg::cbs_t                 cbs_table [policer_pkg::num_ing_ports],
    input  policer_pkg::level_whole_t         levels [policer_pkg::num_ing_ports],
    output logic                              charge_en,
    output policer_pkg::port_t                charge_port,
    output policer_pkg::len_t                 charge_len
);

    logic                          accept;
    logic                          sop_q;
    logic                          port_on;
    logic [policer_pkg::level_w:0] demand;
    logic [policer_pkg::level_w:0] burst;
    logic                          over_burst;
    policer_pkg::policer_meta_t    stamped_meta;
    policer_pkg::policer_meta_t    held_meta_q;

    //////////////////////////////////////////////////
    // Handshake

    // Stage can take a beat when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    //////////////////////////////////////////////////
    // Drop decision

    assign port_on    = port_enable[in_meta.ingress_port];
    assign demand     = (policer_pkg::level_w + 1)'(levels[in_meta.ingress_port]) +
                        (policer_pkg::level_w + 1)'(in_meta.byte_length);
    assign burst      = {1'b0, cbs_table[in_meta.ingress_port].burst_bytes};
    assign over_burst = demand > burst;

    always_comb begin
        stamped_meta.ingress_port      = in_meta.ingress_port;
        stamped_meta.egress_port       = in_meta.egress_port;
        stamped_meta.prio              = in_meta.prio;
        stamped_meta.byte_length       = in_meta.byte_length;
        // Disabled ports pass unmarked
        stamped_meta.policer_drop_mark = port_on && over_burst;
    end

    // Only accepted packets on enabled ports fill the bucket
    assign charge_en   = accept && sop_q && port_on && !over_burst;
    assign charge_port = in_meta.ingress_port;
    assign charge_len  = in_meta.byte_length;

    //////////////////////////////////////////////////
    // Control state

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            out_valid <= 1'b0;
            sop_q     <= 1'b1;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;
            end
            // Next beat after a last one opens a new packet
            if (accept) begin
                sop_q <= in_last;
            end
        end
    end

    //////////////////////////////////////////////////
    // Beat register

    always_ff @(posedge core_clk_ifc) begin
        if (accept) begin
            out_data <= in_data;
            out_last <= in_last;
            out_meta <= sop_q ? stamped_meta : held_meta_q;
        end
        // Keep first-beat verdict for the rest of the packet
        if (accept && sop_q) begin
            held_meta_q <= stamped_meta;
        end
    end

    // Back-pressure must freeze the output beat
    assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("output beat changed under back-pressure");

endmodule

//--- p4_policer_top.sv
/* Ingress token-bucket policer top
   Config tables, bucket bank and marking stage on one beat stream */

`timescale 1ns/1ps

module p4_policer_top (
    input  logic                                  core_clk_ifc,
    input  logic                                  timer_reset,

    // Packet stream in
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic                                  in_last,
    input  logic [policer_pkg::data_w-1:0]        in_data,
    input  policer_pkg::packet_meta_t             in_meta,

    // Packet stream out
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic                                  out_last,
    output logic [policer_pkg::data_w-1:0]        out_data,
    output policer_pkg::policer_meta_t            out_meta,

    // Static per-port enables
    input  logic [policer_pkg::num_ing_ports-1:0] port_enable,

    // Table writes
    input  logic                                  cfg_wr_en,
    input  policer_pkg::cfg_write_t               cfg_wr
);

    policer_pkg::cir_t          cir_table [policer_pkg::num_ing_ports];
    policer_pkg::cbs_t          cbs_table [policer_pkg::num_ing_ports];
    policer_pkg::level_whole_t  levels    [policer_pkg::num_ing_ports];
    logic                       charge_en;
    policer_pkg::port_t         charge_port;
    policer_pkg::len_t          charge_len;

    policer_config_regs u_config_regs (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .cfg_wr_en    (cfg_wr_en),
        .cfg_wr       (cfg_wr),
        .cir_table    (cir_table),
        .cbs_table    (cbs_table)
    );

    policer_bucket_bank u_bucket_bank (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .cir_table    (cir_table),
        .charge_en    (charge_en),
        .charge_port  (charge_port),
        .charge_len   (charge_len),
        .levels       (levels)
    );

    policer_marker u_marker (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_last      (in_last),
        .in_data      (in_data),
        .in_meta      (in_meta),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last),
        .out_data     (out_data),
        .out_meta     (out_meta),
        .port_enable  (port_enable),
        .cbs_table    (cbs_table),
        .levels       (levels),
        .charge_en    (charge_en),
        .charge_port  (charge_port),
        .charge_len   (charge_len)
    );

endmodule

//--- tb_clock_gen.sv
/* Testbench clock source
   Free-running 20 ns clock */

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

//--- p4_policer_tb.sv
/* Policer testbench
   Table-driven stimulus, reference bucket model and in-order output scoreboard */

`timescale 1ns/1ps

module p4_policer_tb;

    localparam int k_cir         = 0;
    localparam int k_cbs         = 1;
    localparam int k_cbs_rand    = 2;
    localparam int k_enable      = 3;
    localparam int k_enable_rand = 4;
    localparam int k_packet      = 5;
    localparam int k_idle        = 6;
    localparam int exp_model     = 2;
    localparam int max_rows      = 32;
    localparam int wait_limit    = 2000;

    logic                                  core_clk_ifc;
    logic                                  timer_reset;
    logic                                  in_valid;
    logic                                  in_ready;
    logic                                  in_last;
    logic [policer_pkg::data_w-1:0]        in_data;
    policer_pkg::packet_meta_t             in_meta;
    logic                                  out_valid;
    logic                                  out_ready;
    logic                                  out_last;
    logic [policer_pkg::data_w-1:0]        out_data;
    policer_pkg::policer_meta_t            out_meta;
    logic [policer_pkg::num_ing_ports-1:0] port_enable;
    logic                                  cfg_wr_en;
    policer_pkg::cfg_write_t               cfg_wr;

    // Step table
    string       row_name   [max_rows];
    int          row_kind   [max_rows];
    int          row_port   [max_rows];
    logic [31:0] row_value  [max_rows];
    int          row_count  [max_rows];
    int          row_expect [max_rows];
    int          num_rows;

    // Scoreboard, beats held as {last, data}
    logic [64:0]                exp_beats [$];
    policer_pkg::policer_meta_t exp_metas [$];
    longint                     model_level [policer_pkg::num_ing_ports];
    longint                     model_cbs   [policer_pkg::num_ing_ports];

    logic [31:0] rng_state;
    logic [31:0] ready_state;
    int          errors;
    int          checks;
    int          tests_run;
    string       current_test;

    tb_clock_gen u_clock_gen (
        .clk (core_clk_ifc)
    );

    p4_policer_top UUT (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_last      (in_last),
        .in_data      (in_data),
        .in_meta      (in_meta),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last),
        .out_data     (out_data),
        .out_meta     (out_meta),
        .port_enable  (port_enable),
        .cfg_wr_en    (cfg_wr_en),
        .cfg_wr       (cfg_wr)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic add_row(input string name, input int kind, input int port,
                           input logic [31:0] value, input int count, input int expect_mark);
        row_name[num_rows]   = name;
        row_kind[num_rows]   = kind;
        row_port[num_rows]   = port;
        row_value[num_rows]  = value;
        row_count[num_rows]  = count;
        row_expect[num_rows] = expect_mark;
        num_rows++;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Stimulus tasks

    // Port below zero means every port
    task automatic write_table(input logic sel, input int port, input logic [31:0] value);
        for (int p = 0; p < policer_pkg::num_ing_ports; p++) begin
            if (port < 0 || port == p) begin
                cfg_wr_en      = 1'b1;
                cfg_wr.table_sel = sel;
                cfg_wr.port    = policer_pkg::port_t'(p);
                if (sel == policer_pkg::cir_table_sel) begin
                    cfg_wr.data.cir = policer_pkg::cir_t'(value);
                end else begin
                    cfg_wr.data.cbs.burst_bytes = value;
                    model_cbs[p] = longint'(value);
                end
                @(posedge core_clk_ifc);
                #1;
                cfg_wr_en = 1'b0;
            end
        end
    endtask

    task automatic send_packet(input int port_sel, input int len_sel, input int exp_sel);
        policer_pkg::packet_meta_t  meta;
        policer_pkg::policer_meta_t exp_meta;
        logic [63:0]                data;
        logic                       mark;
        int                         beats;
        int                         waited;
        int                         p;
        rng_state = xorshift32(rng_state);
        meta.ingress_port = (port_sel < 0) ? policer_pkg::port_t'(rng_state)
                                           : policer_pkg::port_t'(port_sel);
        meta.egress_port  = policer_pkg::port_t'(rng_state >> 4);
        meta.prio         = policer_pkg::prio_t'(rng_state >> 8);
        beats             = 1 + int'(rng_state[17:12]) % 3;
        rng_state = xorshift32(rng_state);
        if (len_sel > 0) begin
            meta.byte_length = policer_pkg::len_t'(len_sel);
        end else begin
            meta.byte_length = policer_pkg::len_t'(1 + rng_state % 1500);
        end
        p = int'(meta.ingress_port);
        // Token bucket rule with no drain
        if (exp_sel != exp_model) begin
            mark = (exp_sel != 0);
        end else if (!port_enable[p]) begin
            mark = 1'b0;
        end else if (model_level[p] + longint'(meta.byte_length) > model_cbs[p]) begin
            mark = 1'b1;
        end else begin
            mark = 1'b0;
            model_level[p] = model_level[p] + longint'(meta.byte_length);
        end
        exp_meta = {meta, mark};
        exp_metas.push_back(exp_meta);
        for (int b = 0; b < beats; b++) begin
            rng_state = xorshift32(rng_state);
            data[63:32] = rng_state;
            rng_state = xorshift32(rng_state);
            data[31:0] = rng_state;
            in_valid = 1'b1;
            in_last  = (b == beats - 1);
            in_data  = data;
            in_meta  = meta;
            exp_beats.push_back({in_last, data});
            @(posedge core_clk_ifc);
            waited = 1;
            while (!in_ready) begin
                if (waited >= wait_limit) begin
                    abort_run("timeout: input beat was never accepted");
                end
                @(posedge core_clk_ifc);
                waited++;
            end
            #1;
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_beats.size() != 0) begin
            if (waited >= wait_limit) begin
                abort_run("timeout: expected output beats never came out");
            end
            @(posedge core_clk_ifc);
            waited++;
        end
        #1;
    endtask

    task automatic apply_row(input int r);
        case (row_kind[r])
            k_cir: write_table(policer_pkg::cir_table_sel, row_port[r], row_value[r]);
            k_cbs: write_table(policer_pkg::cbs_table_sel, row_port[r], row_value[r]);
            k_cbs_rand: begin
                for (int p = 0; p < policer_pkg::num_ing_ports; p++) begin
                    rng_state = xorshift32(rng_state);
                    write_table(policer_pkg::cbs_table_sel, p, rng_state % 4096);
                end
            end
            k_enable: port_enable = row_value[r][policer_pkg::num_ing_ports-1:0];
            k_enable_rand: begin
                rng_state = xorshift32(rng_state);
                port_enable = rng_state[policer_pkg::num_ing_ports-1:0];
            end
            k_packet: begin
                repeat (row_count[r]) begin
                    send_packet(row_port[r], int'(row_value[r]), row_expect[r]);
                end
            end
            default: begin
                repeat (row_count[r]) begin
                    @(posedge core_clk_ifc);
                end
                #1;
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Back-pressure and output monitor

    always @(posedge core_clk_ifc) begin
        #1;
        ready_state = xorshift32(ready_state);
        out_ready = (ready_state[2:0] > 3'd2);
    end

    task automatic check_beat(input logic [64:0] expected);
        policer_pkg::policer_meta_t exp_meta;
        checks++;
        if (out_data !== expected[63:0]) begin
            errors++;
            $display("CHECK FAILED %s data expected %h actual %h",
                     current_test, expected[63:0], out_data);
        end
        if (out_last !== expected[64]) begin
            errors++;
            $display("CHECK FAILED %s last expected %b actual %b",
                     current_test, expected[64], out_last);
        end
        if (expected[64] && exp_metas.size() != 0) begin
            exp_meta = exp_metas.pop_front();
            if (out_meta !== exp_meta) begin
                errors++;
                $display("CHECK FAILED %s meta expected %h actual %h",
                         current_test, exp_meta, out_meta);
            end
        end
    endtask

    always @(posedge core_clk_ifc) begin
        if (!timer_reset && out_valid && out_ready) begin
            if (exp_beats.size() == 0) begin
                errors++;
                $display("%s: output beat appeared with none expected", current_test);
            end else begin
                check_beat(exp_beats.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        int prev_errors;
        timer_reset = 1'b1;
        in_valid    = 1'b0;
        in_last     = 1'b0;
        in_data     = '0;
        in_meta     = '0;
        out_ready   = 1'b0;
        port_enable = '0;
        cfg_wr_en   = 1'b0;
        cfg_wr      = '0;
        rng_state   = 32'd95544;
        ready_state = ~32'd95544;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        num_rows    = 0;
        prev_errors = 0;
        for (int p = 0; p < policer_pkg::num_ing_ports; p++) begin
            model_level[p] = 0;
            model_cbs[p]   = 0;
        end

        add_row("zero_cbs_marks", k_enable, 0, 32'hF, 0, 0);
        add_row("zero_cbs_marks", k_packet, -1, 0, 12, 1);
        add_row("random_cbs_model", k_cbs_rand, -1, 0, 0, 0);
        add_row("random_cbs_model", k_packet, -1, 0, 24, exp_model);
        add_row("max_rate_passes", k_cir, -1, 32'hFFFF_FFFF, 0, 0);
        add_row("max_rate_passes", k_cbs, -1, 32'hFFFF_FFFF, 0, 0);
        add_row("max_rate_passes", k_packet, -1, 0, 12, 0);
        // 4 bytes per clock, so a full bucket empties in 250 clocks
        add_row("cir_drain", k_cir, 1, 32'h0000_0400, 0, 0);
        add_row("cir_drain", k_cbs, 1, 32'd1000, 0, 0);
        add_row("cir_drain", k_packet, 1, 32'd1000, 1, 0);
        add_row("cir_drain", k_packet, 1, 32'd1000, 1, 1);
        add_row("cir_drain", k_idle, 0, 0, 280, 0);
        add_row("cir_drain", k_packet, 1, 32'd1000, 1, 0);
        add_row("port_enable", k_cbs, -1, 0, 0, 0);
        add_row("port_enable", k_enable_rand, 0, 0, 0, 0);
        add_row("port_enable", k_packet, -1, 0, 10, exp_model);
        add_row("port_enable", k_enable_rand, 0, 0, 0, 0);
        add_row("port_enable", k_packet, -1, 0, 10, exp_model);
        add_row("back_pressure", k_cbs, -1, 32'hFFFF_FFFF, 0, 0);
        add_row("back_pressure", k_packet, -1, 0, 20, 0);

        repeat (5) begin
            @(posedge core_clk_ifc);
        end
        #1;
        timer_reset = 1'b0;

        for (int r = 0; r < num_rows; r++) begin
            current_test = row_name[r];
            apply_row(r);
            if (r == num_rows - 1 || row_name[r + 1] != row_name[r]) begin
                drain_outputs();
                tests_run++;
                $display("test %s finished with %0d errors", row_name[r], errors - prev_errors);
                prev_errors = errors;
            end
        end

        if (exp_metas.size() != 0) begin
            errors++;
            $display("%0d packets never produced a last beat", exp_metas.size());
        end
        $display("tests %0d, beat checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- filelist.f
policer_pkg.sv
policer_config_regs.sv
policer_bucket_bank.sv
policer_marker.sv
p4_policer_top.sv
tb_clock_gen.sv
p4_policer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the policer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module p4_policer_tb -o p4_policer_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/p4_policer_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^PASS: all tests$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
